/* decode.f */
+incdir+bench
source/decode_pkg.sv
source/lane_result_if.sv
source/fetch_align.sv
source/decode_lane.sv
source/decode_buffer.sv
source/decode_top.sv
bench/decode_properties.sv
bench/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module decode_tb -f decode.f -o decode_sim \
	> sim.log 2>&1 && ./obj_dir/decode_sim >> sim.log 2>&1 \
	|| echo "SOME TESTS FAILED" >> sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
exit 0

/* bench/decode_model.svh */
// Decode reference model
// Expected lane fields and intra-bundle hazard flags, derived from the
// instruction set rules of the decode stage
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
	reg_t  ra;
	reg_t  rb;
	reg_t  rt;
	logic  rfwr;
	word_t imm;
	logic  branch;
	logic  mem_op;
	logic  ui;
} lane_expect_t;

typedef struct packed {
	logic                     valid;
	addr_t [LANES-1:0]        ip;
	lane_expect_t [LANES-1:0] lane;
	logic [LANES-1:0]         hazard;
} bundle_expect_t;

// The field sits at the top of the word and is shifted down arithmetically
function automatic word_t sign_extend_top(logic [63:0] v, int unsigned drop);
	return word_t'($signed(v) >>> drop);
endfunction

function automatic lane_expect_t decode_insn(insn_t ir);
	lane_expect_t e;
	logic [7:0]   opc;
	opc = ir[7:0];
	e = '0;
	e.ra = ir[19:14];
	e.rb = ir[25:20];
	e.ui = 1'b1;
	case (opc)
		BRK, NOP: e.ui = 1'b0;
		R2: begin
			if (ir[31:26] inside {ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL}) begin
				e.rt   = ir[13:8];
				e.rfwr = 1'b1;
				e.ui   = 1'b0;
			end
		end
		ADDI, SLTI, ANDI, ORI, XORI, SLTUI: begin
			e.rt   = ir[13:8];
			e.rfwr = 1'b1;
			e.ui   = 1'b0;
			if (opc == ANDI)
				e.imm = 64'hFFFF_FFFF_FFFF_F000 | 64'(ir[31:20]);
			else if (opc == ADDI || opc == SLTI)
				e.imm = sign_extend_top({ir[31:20], 52'd0}, 52);
			else
				e.imm = 64'(ir[31:20]);
		end
		JAL: begin
			e.rt   = {4'b0000, ir[9:8]};
			e.rfwr = 1'b1;
			e.ui   = 1'b0;
			e.imm  = sign_extend_top({ir[31:10], 2'b00, 40'd0}, 40);
		end
		BEQ, BNE, BLT, BGE: begin
			e.branch = 1'b1;
			e.ui     = 1'b0;
			e.imm    = sign_extend_top({ir[31:26], ir[13:10], 2'b00, 52'd0}, 52);
		end
		LDX: begin
			e.rt     = ir[13:8];
			e.rfwr   = 1'b1;
			e.mem_op = 1'b1;
			e.ui     = 1'b0;
			e.imm    = sign_extend_top({ir[27:20], 56'd0}, 56);
		end
		STX: begin
			e.mem_op = 1'b1;
			e.ui     = 1'b0;
			e.imm    = sign_extend_top({ir[31:26], ir[13:8], 52'd0}, 52);
		end
		default: ;
	endcase
	return e;
endfunction

function automatic bundle_expect_t expect_bundle(logic valid, addr_t ip,
		insn_t [LANES-1:0] ir);
	bundle_expect_t b;
	b.valid = valid;
	for (int k = 0; k < LANES; k++) begin
		b.ip[k]   = ip + addr_t'(k * INSN_BYTES);
		b.lane[k] = decode_insn(ir[k]);
	end
	// A later lane depends on an earlier lane that writes a nonzero register it reads
	b.hazard = '0;
	for (int k = 1; k < LANES; k++) begin
		for (int j = 0; j < k; j++) begin
			if (b.lane[j].rfwr && b.lane[j].rt != '0 &&
					(b.lane[k].ra == b.lane[j].rt || b.lane[k].rb == b.lane[j].rt))
				b.hazard[k] = 1'b1;
		end
	end
	return b;
endfunction

`endif

/* bench/decode_tb.sv */
// Decode stage testbench
// Seeded random instruction bundles checked against a reference model
// through a two-deep pipeline of expected results
module decode_tb import decode_pkg::*; ();

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid;
	addr_t             in_ip;
	insn_t [LANES-1:0] in_ir;
	logic              out_valid;
	addr_t [LANES-1:0] out_ip;
	reg_t  [LANES-1:0] out_ra;
	reg_t  [LANES-1:0] out_rb;
	reg_t  [LANES-1:0] out_rt;
	logic  [LANES-1:0] out_rfwr;
	word_t [LANES-1:0] out_imm;
	logic  [LANES-1:0] out_branch;
	logic  [LANES-1:0] out_mem_op;
	logic  [LANES-1:0] out_ui;
	logic  [LANES-1:0] out_hazard;
	int                seed;

	`include "decode_model.svh"

	bundle_expect_t pipe [$];
	opcode_e opcode_table [16] = '{BRK, R2, ADDI, SLTI, SLTUI, ANDI, ORI, XORI,
		JAL, BEQ, BNE, BLT, BGE, LDX, STX, NOP};
	func_e func_table [8] = '{ADD, SUB, SLT, SLTU, AND, OR, XOR, MUL};

	decode_top i_dut (.*);

	always #10 clk = ~clk;

	// ====================
	// Checking
	// ====================
	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "Decode testbench stopped on a failure");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bundle(input bundle_expect_t b);
		check_value("out_valid", 64'(out_valid), 64'(b.valid));
		if (b.valid) begin
			check_value("out_hazard", 64'(out_hazard), 64'(b.hazard));
			for (int k = 0; k < LANES; k++) begin
				check_value($sformatf("out_ip[%0d]", k), 64'(out_ip[k]), 64'(b.ip[k]));
				check_value($sformatf("out_ra[%0d]", k), 64'(out_ra[k]), 64'(b.lane[k].ra));
				check_value($sformatf("out_rb[%0d]", k), 64'(out_rb[k]), 64'(b.lane[k].rb));
				check_value($sformatf("out_rt[%0d]", k), 64'(out_rt[k]), 64'(b.lane[k].rt));
				check_value($sformatf("out_rfwr[%0d]", k), 64'(out_rfwr[k]),
					64'(b.lane[k].rfwr));
				check_value($sformatf("out_imm[%0d]", k), out_imm[k], b.lane[k].imm);
				check_value($sformatf("out_branch[%0d]", k), 64'(out_branch[k]),
					64'(b.lane[k].branch));
				check_value($sformatf("out_mem_op[%0d]", k), 64'(out_mem_op[k]),
					64'(b.lane[k].mem_op));
				check_value($sformatf("out_ui[%0d]", k), 64'(out_ui[k]), 64'(b.lane[k].ui));
			end
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic random_insn(output insn_t ir);
		logic [3:0] opc_idx;
		logic [2:0] func_idx;
		ir = $random(seed);
		opc_idx = 4'($random(seed));
		func_idx = 3'($random(seed));
		// About one opcode in ten stays a raw byte and is then mostly unimplemented
		if ($unsigned($random(seed)) % 10 != 0)
			ir[7:0] = opcode_table[opc_idx];
		if (ir[7:0] == R2 && ($random(seed) & 1))
			ir[31:26] = func_table[func_idx];
		// Narrow register numbers so that lanes often share registers
		if (($random(seed) & 3) == 0) begin
			ir[25:23] = 3'b000;
			ir[19:17] = 3'b000;
			ir[13:11] = 3'b000;
		end
	endtask

	task automatic drive_bundle(input logic valid);
		insn_t [LANES-1:0] ir;
		insn_t             one;
		addr_t             ip;
		ip = $random(seed);
		for (int k = 0; k < LANES; k++) begin
			random_insn(one);
			ir[k] = one;
		end
		in_valid = valid;
		in_ip    = ip;
		in_ir    = ir;
		pipe.push_back(expect_bundle(valid, ip, ir));
	endtask

	initial begin
		int cycles;
		seed     = 2;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_ip    = '0;
		in_ir    = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// The first bundle also measures the latency
		drive_bundle(1'b1);
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			in_valid = 1'b0;
		end while (!out_valid && cycles < 20);
		if (!out_valid) begin
			$display("Timeout: out_valid did not rise after the first bundle");
			abort_run();
		end
		check_value("out_valid latency", 64'(cycles), 64'd2);
		check_bundle(pipe.pop_front());

		for (int n = 0; n < 2000; n++) begin
			@(posedge clk);
			#1;
			if (pipe.size() == 2)
				check_bundle(pipe.pop_front());
			else
				check_value("out_valid", 64'(out_valid), 64'd0);
			drive_bundle(($random(seed) & 7) != 0);
		end
		repeat (2) begin
			@(posedge clk);
			#1;
			check_bundle(pipe.pop_front());
			drive_bundle(1'b0);
		end

		if (i_dut.i_props.failures == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Assertion failures: %0d", i_dut.i_props.failures);
			abort_run();
		end
	end

endmodule

/* bench/decode_properties.sv */
// Decode stage properties
// Output invariants of the decode stage bound to the top level
module decode_properties import decode_pkg::*; (
	input logic             clk,
	input logic             rst_n,
	input logic             out_valid,
	input logic [LANES-1:0] out_rfwr,
	input logic [LANES-1:0] out_branch,
	input logic [LANES-1:0] out_ui,
	input logic [LANES-1:0] out_hazard
);

	int failures = 0;

	// Unimplemented instructions and branches never write a register
	a_ui_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		(out_ui & out_rfwr) == '0)
	else begin
		failures++;
		$error("out_ui lane also has out_rfwr");
	end
	a_branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		(out_branch & out_rfwr) == '0)
	else begin
		failures++;
		$error("out_branch lane also has out_rfwr");
	end

	// The first lane has no earlier lane to depend on
	a_lane0_no_hazard: assert property (@(posedge clk) disable iff (!rst_n) !out_hazard[0])
	else begin
		failures++;
		$error("out_hazard set on lane 0");
	end

	a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
	else begin
		failures++;
		$error("out_valid high during reset");
	end

endmodule

bind decode_top decode_properties i_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_rfwr   (out_rfwr),
	.out_branch (out_branch),
	.out_ui     (out_ui),
	.out_hazard (out_hazard)
);

/* source/decode_top.sv */
// Instruction decode stage
// Two-cycle decode of an instruction bundle: aligner, one decoder per lane
// and a registered decode buffer with hazard flags
module decode_top import decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  addr_t                 in_ip,
	input  insn_t [LANES-1:0]     in_ir,
	output logic                  out_valid,
	output addr_t [LANES-1:0]     out_ip,
	output reg_t  [LANES-1:0]     out_ra,
	output reg_t  [LANES-1:0]     out_rb,
	output reg_t  [LANES-1:0]     out_rt,
	output logic  [LANES-1:0]     out_rfwr,
	output word_t [LANES-1:0]     out_imm,
	output logic  [LANES-1:0]     out_branch,
	output logic  [LANES-1:0]     out_mem_op,
	output logic  [LANES-1:0]     out_ui,
	output logic  [LANES-1:0]     out_hazard
);

	logic              lane_valid;
	addr_t [LANES-1:0] lane_ip;
	insn_t [LANES-1:0] lane_ir;

	lane_result_if lane_res [LANES] ();

	fetch_align i_align (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ip      (in_ip),
		.in_ir      (in_ir),
		.lane_valid (lane_valid),
		.lane_ip    (lane_ip),
		.lane_ir    (lane_ir)
	);

	// One identical decoder per lane
	for (genvar k = 0; k < LANES; k++) begin : g_lane
		decode_lane i_lane (
			.valid  (lane_valid),
			.ip     (lane_ip[k]),
			.ir     (lane_ir[k]),
			.result (lane_res[k])
		);
	end

	decode_buffer i_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.lanes      (lane_res),
		.out_valid  (out_valid),
		.out_ip     (out_ip),
		.out_ra     (out_ra),
		.out_rb     (out_rb),
		.out_rt     (out_rt),
		.out_rfwr   (out_rfwr),
		.out_imm    (out_imm),
		.out_branch (out_branch),
		.out_mem_op (out_mem_op),
		.out_ui     (out_ui),
		.out_hazard (out_hazard)
	);

endmodule

/* source/decode_buffer.sv */
// Decode buffer
// Registers the decoded fields of every lane and flags read-after-write
// hazards between lanes of the same bundle
module decode_buffer import decode_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	lane_result_if.buffer         lanes [LANES],
	output logic                  out_valid,
	output addr_t [LANES-1:0]     out_ip,
	output reg_t  [LANES-1:0]     out_ra,
	output reg_t  [LANES-1:0]     out_rb,
	output reg_t  [LANES-1:0]     out_rt,
	output logic  [LANES-1:0]     out_rfwr,
	output word_t [LANES-1:0]     out_imm,
	output logic  [LANES-1:0]     out_branch,
	output logic  [LANES-1:0]     out_mem_op,
	output logic  [LANES-1:0]     out_ui,
	output logic  [LANES-1:0]     out_hazard
);

	logic  [LANES-1:0] l_valid;
	addr_t [LANES-1:0] l_ip;
	reg_t  [LANES-1:0] l_ra;
	reg_t  [LANES-1:0] l_rb;
	reg_t  [LANES-1:0] l_rt;
	logic  [LANES-1:0] l_rfwr;
	word_t [LANES-1:0] l_imm;
	logic  [LANES-1:0] l_branch;
	logic  [LANES-1:0] l_mem_op;
	logic  [LANES-1:0] l_ui;
	logic  [LANES-1:0] hazard;
	logic              bundle_valid;

	// Flatten the interface array so the lanes can be indexed in loops
	for (genvar k = 0; k < LANES; k++) begin : g_gather
		assign l_valid[k]  = lanes[k].valid;
		assign l_ip[k]     = lanes[k].ip;
		assign l_ra[k]     = lanes[k].ra;
		assign l_rb[k]     = lanes[k].rb;
		assign l_rt[k]     = lanes[k].rt;
		assign l_rfwr[k]   = lanes[k].rfwr;
		assign l_imm[k]    = lanes[k].imm;
		assign l_branch[k] = lanes[k].branch;
		assign l_mem_op[k] = lanes[k].mem_op;
		assign l_ui[k]     = lanes[k].ui;
	end

	assign bundle_valid = |l_valid;

	// ====================
	// Hazard check
	// ====================
	// A lane depends on any earlier lane that writes a nonzero Rt it reads.
	// Register 0 is never a real destination
	always_comb begin
		for (int k = 0; k < LANES; k++) begin
			hazard[k] = 1'b0;
			for (int j = 0; j < k; j++) begin
				if (l_rfwr[j] && (l_rt[j] != '0) &&
					((l_ra[k] == l_rt[j]) || (l_rb[k] == l_rt[j])))
					hazard[k] = 1'b1;
			end
		end
	end

	// ====================
	// Output registers
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			out_rfwr   <= '0;
			out_branch <= '0;
			out_mem_op <= '0;
			out_ui     <= '0;
			out_hazard <= '0;
		end else begin
			out_valid <= bundle_valid;
			if (bundle_valid) begin
				out_rfwr   <= l_rfwr;
				out_branch <= l_branch;
				out_mem_op <= l_mem_op;
				out_ui     <= l_ui;
				out_hazard <= hazard;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bundle_valid) begin
			out_ip  <= l_ip;
			out_ra  <= l_ra;
			out_rb  <= l_rb;
			out_rt  <= l_rt;
			out_imm <= l_imm;
		end
	end

endmodule

/* source/decode_lane.sv */
// Lane decoder
// Combinational decode of a single instruction into register specifiers,
// register write enable, extended immediate and class flags
module decode_lane import decode_pkg::*; (
	input  logic          valid,
	input  addr_t         ip,
	input  insn_t         ir,
	lane_result_if.lane   result
);

	opcode_e opc;
	func_e   func;
	reg_t    rt;
	logic    rfwr;
	word_t   imm;
	logic    branch;
	logic    mem_op;
	logic    ui;

	assign opc  = opcode_e'(ir[OPC_HI:OPC_LO]);
	assign func = func_e'(ir[FUNC_HI:FUNC_LO]);

	// ====================
	// Instruction decode
	// ====================
	always_comb begin
		// Anything not matched below stays unimplemented and writes nothing
		rt     = '0;
		rfwr   = 1'b0;
		imm    = '0;
		branch = 1'b0;
		mem_op = 1'b0;
		ui     = 1'b1;
		case (opc)
			BRK, NOP: begin
				ui = 1'b0;
			end
			R2: begin
				case (func)
					ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL: begin
						rt   = ir[RT_HI:RT_LO];
						rfwr = 1'b1;
						ui   = 1'b0;
					end
					default: ;
				endcase
			end
			ADDI, SLTI: begin
				rt   = ir[RT_HI:RT_LO];
				rfwr = 1'b1;
				imm  = {{(WORD_WIDTH-IMM_WIDTH){ir[IMM_HI]}}, ir[IMM_HI:IMM_LO]};
				ui   = 1'b0;
			end
			ANDI: begin
				// Ones above the field so the upper word is preserved by the AND
				rt   = ir[RT_HI:RT_LO];
				rfwr = 1'b1;
				imm  = {{(WORD_WIDTH-IMM_WIDTH){1'b1}}, ir[IMM_HI:IMM_LO]};
				ui   = 1'b0;
			end
			ORI, XORI, SLTUI: begin
				rt   = ir[RT_HI:RT_LO];
				rfwr = 1'b1;
				imm  = {{(WORD_WIDTH-IMM_WIDTH){1'b0}}, ir[IMM_HI:IMM_LO]};
				ui   = 1'b0;
			end
			JAL: begin
				// Only a small set of link registers is reachable from the 2-bit field
				rt   = {{(REG_WIDTH-LINK_WIDTH){1'b0}}, ir[LINK_HI:LINK_LO]};
				rfwr = 1'b1;
				imm  = {{(WORD_WIDTH-JOFS_WIDTH){ir[JOFS_HI]}}, ir[JOFS_HI:JOFS_LO], 2'b00};
				ui   = 1'b0;
			end
			BEQ, BNE, BLT, BGE: begin
				branch = 1'b1;
				imm    = {{(WORD_WIDTH-BOFS_WIDTH){ir[FUNC_HI]}}, ir[FUNC_HI:FUNC_LO],
					ir[BOFS_HI:BOFS_LO], 2'b00};
				ui     = 1'b0;
			end
			LDX: begin
				rt     = ir[RT_HI:RT_LO];
				rfwr   = 1'b1;
				mem_op = 1'b1;
				imm    = {{(WORD_WIDTH-DISP_WIDTH){ir[DISP_HI]}}, ir[DISP_HI:DISP_LO]};
				ui     = 1'b0;
			end
			STX: begin
				// Store displacement reuses the func and Rt fields since Rt is not written
				mem_op = 1'b1;
				imm    = {{(WORD_WIDTH-ST_DISP_WIDTH){ir[FUNC_HI]}}, ir[FUNC_HI:FUNC_LO],
					ir[RT_HI:RT_LO]};
				ui     = 1'b0;
			end
			default: ;
		endcase
	end

	// ====================
	// Lane result
	// ====================
	assign result.valid  = valid;
	assign result.ip     = ip;
	assign result.ra     = ir[RA_HI:RA_LO];
	assign result.rb     = ir[RB_HI:RB_LO];
	assign result.rt     = rt;
	assign result.rfwr   = rfwr;
	assign result.imm    = imm;
	assign result.branch = branch;
	assign result.mem_op = mem_op;
	assign result.ui     = ui;

endmodule

/* source/fetch_align.sv */
// Fetch aligner
// Registers an incoming instruction bundle and hands every lane its
// instruction together with its own fetch address
module fetch_align import decode_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  addr_t                in_ip,
	input  insn_t [LANES-1:0]    in_ir,
	output logic                 lane_valid,
	output addr_t [LANES-1:0]    lane_ip,
	output insn_t [LANES-1:0]    lane_ir
);

	addr_t ip_q;

	// Bundle strobe shared by all lanes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_valid <= 1'b0;
		end else begin
			lane_valid <= in_valid;
		end
	end

	// Bundle payload only loads with a valid strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			ip_q    <= in_ip;
			lane_ir <= in_ir;
		end
	end

	// Lane k sits k instruction words past the bundle address
	for (genvar k = 0; k < LANES; k++) begin : g_lane_ip
		assign lane_ip[k] = ip_q + ADDR_WIDTH'(k * INSN_BYTES);
	end

endmodule

/* source/lane_result_if.sv */
// Lane result interface
// Carries the decoded fields of one instruction from its lane decoder
// to the decode buffer
interface lane_result_if import decode_pkg::*; ();

	logic  valid;
	addr_t ip;
	reg_t  ra;
	reg_t  rb;
	reg_t  rt;
	logic  rfwr;
	word_t imm;
	logic  branch;
	logic  mem_op;
	logic  ui;

	// Decoder side
	modport lane (output valid, ip, ra, rb, rt, rfwr, imm, branch, mem_op, ui);

	// Buffer side
	modport buffer (input valid, ip, ra, rb, rt, rfwr, imm, branch, mem_op, ui);

endinterface

/* source/decode_pkg.sv */
// Decode stage package
// Widths, opcode and function encodings and instruction field positions
// shared by the fetch aligner, the lane decoders and the decode buffer
package decode_pkg;

	// ====================
	// Widths
	// ====================
	localparam int LANES      = 2;
	localparam int INSN_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 64;
	localparam int REG_WIDTH  = 6;
	localparam int INSN_BYTES = 4;

	typedef logic [INSN_WIDTH-1:0] insn_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [REG_WIDTH-1:0]  reg_t;

	// ====================
	// Field positions
	// ====================
	localparam int OPC_HI  = 7;
	localparam int OPC_LO  = 0;
	localparam int RT_HI   = 13;
	localparam int RT_LO   = 8;
	localparam int RA_HI   = 19;
	localparam int RA_LO   = 14;
	localparam int RB_HI   = 25;
	localparam int RB_LO   = 20;
	localparam int FUNC_HI = 31;
	localparam int FUNC_LO = 26;
	localparam int IMM_HI  = 31;
	localparam int IMM_LO  = 20;
	localparam int DISP_HI = 27;
	localparam int DISP_LO = 20;
	localparam int LINK_HI = 9;
	localparam int LINK_LO = 8;

	// Branch offset is split between the func field and the bits above Rt[1:0]
	localparam int BOFS_HI = 13;
	localparam int BOFS_LO = 10;
	// JAL offset covers everything above the link register field
	localparam int JOFS_HI = 31;
	localparam int JOFS_LO = 10;

	// Widths of the raw immediate fields before extension
	localparam int IMM_WIDTH     = IMM_HI - IMM_LO + 1;
	localparam int DISP_WIDTH    = DISP_HI - DISP_LO + 1;
	localparam int LINK_WIDTH    = LINK_HI - LINK_LO + 1;
	localparam int JOFS_WIDTH    = JOFS_HI - JOFS_LO + 1 + 2;
	localparam int BOFS_WIDTH    = (FUNC_HI - FUNC_LO + 1) + (BOFS_HI - BOFS_LO + 1) + 2;
	localparam int ST_DISP_WIDTH = (FUNC_HI - FUNC_LO + 1) + (RT_HI - RT_LO + 1);

	// ====================
	// Encodings
	// ====================
	typedef enum logic [7:0] {
		BRK   = 8'h00,
		R2    = 8'h02,
		ADDI  = 8'h04,
		SLTI  = 8'h06,
		SLTUI = 8'h07,
		ANDI  = 8'h08,
		ORI   = 8'h09,
		XORI  = 8'h0A,
		JAL   = 8'h40,
		BEQ   = 8'h48,
		BNE   = 8'h49,
		BLT   = 8'h4A,
		BGE   = 8'h4B,
		LDX   = 8'h60,
		STX   = 8'h70,
		NOP   = 8'hF1
	} opcode_e;

	// Function codes for R2 in bits 31..26
	typedef enum logic [5:0] {
		ADD  = 6'h04,
		SUB  = 6'h05,
		SLT  = 6'h06,
		SLTU = 6'h07,
		AND  = 6'h08,
		OR   = 6'h09,
		XOR  = 6'h0A,
		MUL  = 6'h10
	} func_e;

endpackage
